/* logic/serial_defs.svh */
// -----------------------------------------------
// serial echo line parameters
// clock rate, baud rate and derived bit timing
// -----------------------------------------------

`ifndef SERIAL_DEFS_SVH
`define SERIAL_DEFS_SVH

// main clock in Hz
`define SERIAL_MAIN_CLK_HZ 27_000_000

// line rate in baud
`define SERIAL_BAUD 115_200

// data bits per character, 8N1 framing
`define SERIAL_BITS 8

// clocks per bit, rounded quotient (234 at 27 MHz)
`define SERIAL_CLKS_PER_BIT ((`SERIAL_MAIN_CLK_HZ + `SERIAL_BAUD / 2) / `SERIAL_BAUD)

`endif

/* logic/serial_pkg.sv */
// -----------------------------------------------
// serial echo types
// character and echo controller state
// -----------------------------------------------

`include "serial_defs.svh"

package serial_pkg;

	// one character on the line
	typedef logic [`SERIAL_BITS-1:0] char_t;

	// hold register occupancy
	typedef enum logic {
		EMPTY,
		HELD
	} echo_state_t;

endpackage

/* logic/serial_rx.sv */
// -----------------------------------------------
// 8N1 asynchronous receiver
// synchronizes the line, samples mid-bit, low bit
// first, and flags frames with a bad stop bit
// -----------------------------------------------

`timescale 1ns/100ps

`include "serial_defs.svh"

module serial_rx #(
	parameter int CLKS_PER_BIT = `SERIAL_CLKS_PER_BIT
) (
	input  logic              clk27,
	input  logic              rst,
	input  logic              serial_rx,
	output serial_pkg::char_t rx_char,
	output logic              rx_valid,
	output logic              frame_err
);
	import serial_pkg::*;

	localparam int CNT_W    = $clog2(CLKS_PER_BIT);
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int BIT_W    = $clog2(`SERIAL_BITS);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic             sync_q1;
	logic             sync_q2;
	// set after a framing error until the line is back high
	logic             wait_high;
	char_t            shift_q;

	// end of a full bit and end of half a bit
	wire bit_end  = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	wire half_end = (clk_cnt == CNT_W'(HALF_BIT - 1));
	wire last_bit = (bit_cnt == BIT_W'(`SERIAL_BITS - 1));

	// -----------------------------------------------
	// input synchronizer, idle line is high
	// -----------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			sync_q1 <= 1'b1;
			sync_q2 <= 1'b1;
		end else begin
			sync_q1 <= serial_rx;
			sync_q2 <= sync_q1;
		end
	end

	// -----------------------------------------------
	// frame fsm
	// -----------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state     <= RX_IDLE;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
			wait_high <= 1'b0;
		end else begin
			// strobes last one cycle
			rx_valid  <= 1'b0;
			frame_err <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					if (sync_q2)
						wait_high <= 1'b0;
					else if (!wait_high)
						state <= RX_START;
				end
				RX_START: begin
					// half a bit in, start bit must still be low
					if (half_end) begin
						clk_cnt <= '0;
						state   <= sync_q2 ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						clk_cnt <= '0;
						state   <= RX_IDLE;
						// stop bit low means a broken frame, drop it
						if (sync_q2) begin
							rx_valid <= 1'b1;
						end else begin
							frame_err <= 1'b1;
							wait_high <= 1'b1;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data shift, low bit arrives first so shift right
	always_ff @(posedge clk27) begin
		if (state == RX_DATA && bit_end)
			shift_q <= {sync_q2, shift_q[`SERIAL_BITS-1:1]};
	end

	// stays stable through the stop bit
	assign rx_char = shift_q;

endmodule

/* logic/serial_tx.sv */
// -----------------------------------------------
// 8N1 asynchronous transmitter
// start bit, data low bit first, stop bit
// -----------------------------------------------

`timescale 1ns/100ps

`include "serial_defs.svh"

module serial_tx #(
	parameter int CLKS_PER_BIT = `SERIAL_CLKS_PER_BIT
) (
	input  logic              clk27,
	input  logic              rst,
	input  serial_pkg::char_t tx_char,
	input  logic              tx_start,
	output logic              serial_tx,
	output logic              tx_busy
);
	import serial_pkg::*;

	// start + data + stop
	localparam int FRAME_BITS = `SERIAL_BITS + 2;
	localparam int CNT_W      = $clog2(CLKS_PER_BIT);
	localparam int BIT_W      = $clog2(FRAME_BITS);

	logic [CNT_W-1:0] clk_cnt;
	// bit index in frame, 0 is the start bit
	logic [BIT_W-1:0] bit_cnt;
	char_t            data_q;

	wire bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	// last data bit, next one is the stop bit
	wire data_last = (bit_cnt == BIT_W'(`SERIAL_BITS));
	wire stop_last = (bit_cnt == BIT_W'(FRAME_BITS - 1));

	// -----------------------------------------------
	// line and bit timing
	// -----------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			serial_tx <= 1'b1;
			tx_busy   <= 1'b0;
			clk_cnt   <= '0;
			bit_cnt   <= '0;
		end else if (!tx_busy) begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			// start bit goes out right away
			if (tx_start) begin
				serial_tx <= 1'b0;
				tx_busy   <= 1'b1;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			bit_cnt <= bit_cnt + 1'b1;
			if (stop_last)
				tx_busy <= 1'b0;
			else if (data_last)
				serial_tx <= 1'b1;
			else
				serial_tx <= data_q[0];
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// character shift register, next data bit sits in bit 0
	always_ff @(posedge clk27) begin
		if (!tx_busy && tx_start)
			data_q <= tx_char;
		else if (tx_busy && bit_end && !data_last && !stop_last)
			data_q <= data_q >> 1;
	end

endmodule

/* logic/echo_ctrl.sv */
// -----------------------------------------------
// echo controller
// one character hold register between rx and tx
// -----------------------------------------------

`timescale 1ns/100ps

module echo_ctrl (
	input  logic              clk27,
	input  logic              rst,
	input  serial_pkg::char_t rx_char,
	input  logic              rx_valid,
	input  logic              tx_busy,
	output serial_pkg::char_t tx_char,
	output logic              tx_start
);
	import serial_pkg::*;

	echo_state_t state;
	char_t       hold_q;

	// kick the transmitter as soon as it is idle
	assign tx_start = (state == HELD) && !tx_busy;
	assign tx_char  = hold_q;

	// -----------------------------------------------
	// hold register occupancy
	// -----------------------------------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= EMPTY;
		end else begin
			// new character wins over the handoff
			if (rx_valid)
				state <= HELD;
			else if (tx_start)
				state <= EMPTY;
		end
	end

	// rx and tx share one rate, so no overrun here;
	// a character landing with tx_start is kept for the next echo
	always_ff @(posedge clk27) begin
		if (rx_valid)
			hold_q <= rx_char;
	end

endmodule

/* logic/serial_echo.sv */
// -----------------------------------------------
// serial echo top level
// receiver, echo controller and transmitter
// -----------------------------------------------

`timescale 1ns/100ps

`include "serial_defs.svh"

module serial_echo (
	input  logic clk27,
	input  logic rst,
	input  logic serial_rx,
	output logic serial_tx,
	output logic frame_error
);
	import serial_pkg::*;

	// rx to controller
	char_t rx_char;
	logic  rx_valid;
	logic  frame_err;

	// controller and tx
	char_t tx_char;
	logic  tx_start;
	logic  tx_busy;

	serial_rx #(
		.CLKS_PER_BIT(`SERIAL_CLKS_PER_BIT)
	) i_serial_rx (
		.clk27    (clk27),
		.rst      (rst),
		.serial_rx(serial_rx),
		.rx_char  (rx_char),
		.rx_valid (rx_valid),
		.frame_err(frame_err)
	);

	echo_ctrl i_echo_ctrl (
		.clk27   (clk27),
		.rst     (rst),
		.rx_char (rx_char),
		.rx_valid(rx_valid),
		.tx_busy (tx_busy),
		.tx_char (tx_char),
		.tx_start(tx_start)
	);

	serial_tx #(
		.CLKS_PER_BIT(`SERIAL_CLKS_PER_BIT)
	) i_serial_tx (
		.clk27    (clk27),
		.rst      (rst),
		.tx_char  (tx_char),
		.tx_start (tx_start),
		.serial_tx(serial_tx),
		.tx_busy  (tx_busy)
	);

	// broken frames are reported, not echoed
	assign frame_error = frame_err;

endmodule

/* tb/tb_clkgen.sv */
// -----------------------------------------------
// testbench clock and power-on reset
// 40 ns clock, reset held for 4 cycles
// -----------------------------------------------

`timescale 1ns/100ps

module tb_clkgen (
	output logic clk27,
	output logic rst
);
	// half of the 40 ns period
	localparam int HALF_NS = 20;

	initial begin
		clk27 = 1'b0;
		forever
			#HALF_NS clk27 = ~clk27;
	end

	// release just after a rising edge
	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk27);
		#2 rst = 1'b0;
	end

endmodule

/* tb/serial_echo_chk.sv */
// -----------------------------------------------
// serial echo protocol checks
// receiver strobes, tx handoff, line after reset
// -----------------------------------------------

`timescale 1ns/100ps

module serial_echo_chk (
	input logic clk27,
	input logic rst,
	input logic serial_rx,
	input logic rx_valid,
	input logic frame_err,
	input logic tx_start,
	input logic tx_busy,
	input logic serial_tx
);
	// failed assertion count
	int fail_cnt = 0;

	// one strobe per frame that follows the stop bit on the line
	// stop sample is the pin three edges back through the synchronizer
	a_rx_excl: assert property (@(posedge clk27) disable iff (rst)
		(rx_valid || frame_err) |->
			(rx_valid != frame_err) && (rx_valid == $past(serial_rx, 3)))
	else begin
		$error("receiver strobe does not match the stop bit on serial_rx");
		fail_cnt++;
	end

	// handoff only to an idle transmitter which then goes busy
	a_tx_free: assert property (@(posedge clk27) disable iff (rst)
		tx_start |-> !tx_busy ##1 tx_busy)
	else begin
		$error("tx_start while tx_busy is high or transmitter did not start");
		fail_cnt++;
	end

	// idle line right out of reset
	a_tx_idle: assert property (@(posedge clk27) $fell(rst) |-> serial_tx)
	else begin
		$error("serial_tx low in the cycle after reset release");
		fail_cnt++;
	end

endmodule

bind serial_echo serial_echo_chk i_serial_echo_chk (
	.clk27    (clk27),
	.rst      (rst),
	.serial_rx(serial_rx),
	.rx_valid (rx_valid),
	.frame_err(frame_err),
	.tx_start (tx_start),
	.tx_busy  (tx_busy),
	.serial_tx(serial_tx)
);

/* tb/serial_echo_tb.sv */
// -----------------------------------------------
// serial echo testbench
// directed tests, serial driver and line monitor
// -----------------------------------------------

`timescale 1ns/100ps

`include "serial_defs.svh"

module serial_echo_tb;
	import serial_pkg::*;

	localparam int CPB   = `SERIAL_CLKS_PER_BIT;
	localparam int BITS  = `SERIAL_BITS;
	// one 8N1 frame in clocks
	localparam int FRAME = 10 * CPB;
	localparam int LIMIT = 30 * FRAME + 2000;

	logic  clk27;
	logic  rst_por;
	logic  rst_force;
	logic  rst;
	logic  serial_rx;
	logic  serial_tx;
	logic  frame_error;

	// characters seen on serial_tx
	char_t rx_q[$];
	int    err_cnt   = 0;
	int    pass_cnt  = 0;
	int    fail_cnt  = 0;
	int    ferr_cnt  = 0;
	int    cycle_cnt = 0;
	int    seed;

	// power-on reset or a forced one mid-run
	assign rst = rst_por | rst_force;

	tb_clkgen i_tb_clkgen (
		.clk27(clk27),
		.rst  (rst_por)
	);

	serial_echo i_serial_echo (
		.clk27      (clk27),
		.rst        (rst),
		.serial_rx  (serial_rx),
		.serial_tx  (serial_tx),
		.frame_error(frame_error)
	);

	// -----------------------------------------------
	// run limit and frame error counter
	// -----------------------------------------------
	always @(posedge clk27) begin
		cycle_cnt++;
		if (cycle_cnt >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// pulse spans one full cycle, so negedge sees it once
	always @(negedge clk27)
		if (frame_error === 1'b1)
			ferr_cnt++;

	// -----------------------------------------------
	// serial driver
	// -----------------------------------------------
	// one bit lasts CPB clocks, driven 2 ns after the edge
	task automatic drive_bit(input logic v);
		@(posedge clk27);
		#2 serial_rx = v;
		repeat (CPB - 1) @(posedge clk27);
	endtask

	task automatic send_frame(input char_t ch, input logic stop);
		char_t sh;
		int    i;
		sh = ch;
		drive_bit(1'b0);
		// low bit first
		for (i = 0; i < BITS; i++) begin
			drive_bit(sh[0]);
			sh = sh >> 1;
		end
		drive_bit(stop);
	endtask

	// -----------------------------------------------
	// line monitor
	// -----------------------------------------------
	task automatic count_cycles(input int n, inout logic hit_rst);
		int k;
		for (k = 0; k < n; k++) begin
			@(posedge clk27);
			if (rst)
				hit_rst = 1'b1;
		end
	endtask

	task automatic capture_frame();
		char_t ch;
		logic  hit_rst;
		logic  stop_bit;
		int    i;
		hit_rst = 1'b0;
		ch = '0;
		@(negedge serial_tx);
		count_cycles(CPB / 2, hit_rst);
		// glitch, not a start bit
		if (serial_tx !== 1'b0)
			return;
		for (i = 0; i < BITS; i++) begin
			count_cycles(CPB, hit_rst);
			ch = {serial_tx, ch[BITS-1:1]};
		end
		count_cycles(CPB, hit_rst);
		stop_bit = serial_tx;
		// frame cut by reset is dropped
		if (hit_rst)
			return;
		assert (stop_bit === 1'b1) else begin
			$display("Error %0t: echo stop bit expected 1 got %b", $time, stop_bit);
			err_cnt++;
		end
		rx_q.push_back(ch);
	endtask

	initial begin
		forever
			capture_frame();
	end

	// -----------------------------------------------
	// check helpers
	// -----------------------------------------------
	task automatic wait_echo(input int n);
		int k;
		k = 0;
		while (rx_q.size() < n && k < 2 * FRAME) begin
			@(posedge clk27);
			k++;
		end
		assert (rx_q.size() >= n) else begin
			$display("no character came back in time, got %0d of %0d", rx_q.size(), n);
			err_cnt++;
		end
	endtask

	// line stays high for nbits bit times
	task automatic expect_idle(input int nbits);
		int k;
		bit bad;
		bad = 1'b0;
		for (k = 0; k < nbits * CPB; k++) begin
			@(negedge clk27);
			if (!bad) begin
				assert (serial_tx === 1'b1) else begin
					$display("Error %0t: serial_tx expected 1 got %b", $time, serial_tx);
					err_cnt++;
					bad = 1'b1;
				end
			end
		end
	endtask

	task automatic check_char(input char_t exp, input char_t got);
		assert (got === exp) else begin
			$display("Error %0t: echoed character expected %02h got %02h", $time, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int got);
		assert (got == exp) else begin
			$display("Error %0t: %s expected %0d got %0d", $time, what, exp, got);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: fail, %0d errors", name, err_cnt - errs_before);
		end
	endtask

	// -----------------------------------------------
	// directed tests
	// -----------------------------------------------
	task automatic idle_after_reset();
		int e;
		e = err_cnt;
		expect_idle(20);
		check_count("frame_error pulses", 0, ferr_cnt);
		check_count("echoed characters", 0, rx_q.size());
		finish_test("idle_after_reset", e);
	endtask

	task automatic single_echo();
		int e;
		e = err_cnt;
		rx_q.delete();
		send_frame(8'hA5, 1'b1);
		wait_echo(1);
		// nothing more may follow
		expect_idle(10);
		check_count("echoed characters", 1, rx_q.size());
		if (rx_q.size() > 0)
			check_char(8'hA5, rx_q[0]);
		finish_test("single_echo", e);
	endtask

	task automatic burst_echo();
		char_t       exp_q[$];
		logic [31:0] r;
		int          e;
		int          i;
		e = err_cnt;
		rx_q.delete();
		seed = 95;
		// back to back, no idle between frames
		for (i = 0; i < 12; i++) begin
			r = $random(seed);
			exp_q.push_back(r[BITS-1:0]);
			send_frame(r[BITS-1:0], 1'b1);
		end
		wait_echo(12);
		check_count("echoed characters", 12, rx_q.size());
		for (i = 0; i < 12 && i < rx_q.size(); i++)
			check_char(exp_q[i], rx_q[i]);
		finish_test("burst_echo", e);
	endtask

	task automatic bad_stop_bit();
		int e;
		int f0;
		e = err_cnt;
		f0 = ferr_cnt;
		rx_q.delete();
		send_frame(8'h3C, 1'b0);
		// back to idle after the broken stop bit
		drive_bit(1'b1);
		expect_idle(10);
		check_count("frame_error pulses", 1, ferr_cnt - f0);
		check_count("echoed characters", 0, rx_q.size());
		// receiver must recover
		send_frame(8'h5A, 1'b1);
		wait_echo(1);
		if (rx_q.size() > 0)
			check_char(8'h5A, rx_q[0]);
		finish_test("bad_stop_bit", e);
	endtask

	task automatic reset_during_echo();
		int e;
		e = err_cnt;
		rx_q.delete();
		send_frame(8'hC3, 1'b1);
		// echo began half a bit ago, go a few bits into it
		repeat (4 * CPB) @(posedge clk27);
		#2 rst_force = 1'b1;
		repeat (4) @(posedge clk27);
		#2 rst_force = 1'b0;
		// cut echo must not resume
		expect_idle(12);
		check_count("echoed characters", 0, rx_q.size());
		send_frame(8'h96, 1'b1);
		wait_echo(1);
		check_count("echoed characters", 1, rx_q.size());
		if (rx_q.size() > 0)
			check_char(8'h96, rx_q[0]);
		finish_test("reset_during_echo", e);
	endtask

	// -----------------------------------------------
	// main sequence
	// -----------------------------------------------
	initial begin
		serial_rx = 1'b1;
		rst_force = 1'b0;
		wait (rst_por === 1'b0);
		idle_after_reset();
		single_echo();
		burst_echo();
		bad_stop_bit();
		reset_during_echo();
		if (i_serial_echo.i_serial_echo_chk.fail_cnt != 0)
			$display("protocol assertions failed %0d times",
				i_serial_echo.i_serial_echo_chk.fail_cnt);
		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && i_serial_echo.i_serial_echo_chk.fail_cnt == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+logic
logic/serial_pkg.sv
logic/serial_rx.sv
logic/serial_tx.sv
logic/echo_ctrl.sv
logic/serial_echo.sv
tb/tb_clkgen.sv
tb/serial_echo_chk.sv
tb/serial_echo_tb.sv

/* Makefile */
TOP = serial_echo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
